// File: compile.f
+incdir+logic
logic/pkt_sched_pkg.sv
logic/core_msg_arbiter.sv
logic/core_select.sv
logic/slot_table.sv
logic/sched_ctrl.sv
logic/pkt_sched_top.sv
sim/pkt_sched_checker.sv
sim/tb_pkt_sched.sv

// File: logic/core_msg_arbiter.sv
// Per-core message holding registers with round-robin hand-off to the controller
`timescale 1ns/1ps
`include "pkt_sched_macros.svh"

module core_msg_arbiter (
  input  logic                     logic_clk,
  input  logic                     rst_n,
  input  pkt_sched_pkg::core_msg_u core_msg_data [`CORE_COUNT],
  input  logic [`CORE_COUNT-1:0]   core_msg_valid,
  output logic [`CORE_COUNT-1:0]   core_msg_ready,
  output pkt_sched_pkg::core_msg_u msg_data,
  output pkt_sched_pkg::core_idx_t msg_core,
  output logic                     msg_valid,
  input  logic                     msg_ready
);
  import pkt_sched_pkg::*;

  core_msg_u              hold_data [`CORE_COUNT];
  logic [`CORE_COUNT-1:0] hold_full;
  logic [`CORE_COUNT-1:0] grant;
  logic [`CORE_COUNT-1:0] avail;
  logic                   pick_valid;
  core_idx_t              pick_core;

  assign core_msg_ready = core_msg_valid & ~hold_full;

  // Register released by the current handshake
  always_comb begin
    grant = '0;
    grant[msg_core] = msg_valid && msg_ready;
  end

  assign avail = hold_full & ~grant;

  // Search starts after the core presented last
  always_comb begin
    core_idx_t cand;
    pick_valid = 1'b0;
    pick_core  = msg_core;
    for (int i = 1; i <= `CORE_COUNT; i++) begin
      cand = core_idx_t'(msg_core + i);
      if (!pick_valid && avail[cand]) begin
        pick_valid = 1'b1;
        pick_core  = cand;
      end
    end
  end

  always_ff @(posedge logic_clk) begin
    for (int c = 0; c < `CORE_COUNT; c++) begin
      if (core_msg_ready[c]) begin
        hold_data[c] <= core_msg_data[c];
      end
    end
  end

  always_ff @(posedge logic_clk or negedge rst_n) begin
    if (!rst_n) begin
      hold_full <= '0;
      msg_valid <= 1'b0;
      msg_core  <= core_idx_t'(`CORE_COUNT - 1);
    end else begin
      hold_full <= avail | core_msg_ready;
      if (!msg_valid || msg_ready) begin
        msg_valid <= pick_valid;
        msg_core  <= pick_core;
      end
    end
  end

  assign msg_data = hold_data[msg_core];

  // Presented message stays put until the controller takes it
  assert property (@(posedge logic_clk) disable iff (!rst_n)
    msg_valid && !msg_ready |=> msg_valid && $stable(msg_data) && $stable(msg_core));

endmodule

// File: logic/core_select.sv
// Round-robin choice of an enabled core with a free slot and its lowest free slot
`timescale 1ns/1ps
`include "pkt_sched_macros.svh"

module core_select (
  input  logic                                    logic_clk,
  input  logic                                    rst_n,
  input  logic [`CORE_COUNT-1:0][`SLOT_COUNT-1:0] slot_busy,
  input  logic [`CORE_COUNT-1:0]                  core_enable,
  input  logic                                    take,
  output logic                                    sel_valid,
  output pkt_sched_pkg::core_idx_t                sel_core,
  output pkt_sched_pkg::slot_idx_t                sel_slot
);
  import pkt_sched_pkg::*;

  core_idx_t last_core;

  always_comb begin
    core_idx_t cand;
    sel_valid = 1'b0;
    sel_core  = '0;
    for (int i = 1; i <= `CORE_COUNT; i++) begin
      cand = core_idx_t'(last_core + i);
      if (!sel_valid && core_enable[cand] && !(&slot_busy[cand])) begin
        sel_valid = 1'b1;
        sel_core  = cand;
      end
    end
  end

  // Downward scan so the lowest free slot wins
  always_comb begin
    sel_slot = '0;
    for (int s = `SLOT_COUNT - 1; s >= 0; s--) begin
      if (!slot_busy[sel_core][s]) begin
        sel_slot = slot_idx_t'(s);
      end
    end
  end

  always_ff @(posedge logic_clk or negedge rst_n) begin
    if (!rst_n) begin
      last_core <= core_idx_t'(`CORE_COUNT - 1);
    end else if (take) begin
      last_core <= sel_core;
    end
  end

endmodule

// File: logic/pkt_sched_macros.svh
// Width, count and address-map macros for the packet scheduler
`ifndef PKT_SCHED_MACROS_SVH
`define PKT_SCHED_MACROS_SVH

// Core and slot geometry
`define CORE_COUNT 8
`define CORE_W 3
`define SLOT_COUNT 8
`define SLOT_W 3

// Offsets count 512 byte units, core windows sit 64 KiB apart
`define SLOT_OFS_W 7
`define SLOT_SHIFT 9
`define ADDR_W 19

`define LEN_W 16
`define TAG_W 8
`define MSG_W 64

// Host port
`define WB_ADR_W 7
`define WB_DAT_W 8
`define ENABLE_REG_ADR 64

`endif

// File: logic/pkt_sched_pkg.sv
// Index types and core message union for the packet scheduler
`include "pkt_sched_macros.svh"

package pkt_sched_pkg;

  typedef logic [`CORE_W-1:0] core_idx_t;
  typedef logic [`SLOT_W-1:0] slot_idx_t;

  typedef enum logic {
    MSG_SEND = 1'b0,
    MSG_DROP = 1'b1
  } msg_kind_t;

  // Kind and slot share the top bits in both views
  typedef union packed {
    struct packed {
      msg_kind_t             kind;
      slot_idx_t             slot;
      logic [11:0]           spare;
      logic [`LEN_W-1:0]     len;
      logic [31:0]           rsvd;
    } send;
    struct packed {
      msg_kind_t             kind;
      slot_idx_t             slot;
      // Reason code from the core that the design ignores
      logic [`MSG_W-1-`SLOT_W-1:0] reason;
    } drop;
  } core_msg_u;

endpackage

// File: logic/pkt_sched_top.sv
// Packet scheduler top level joining controller, slot table, core selector and arbiter
`timescale 1ns/1ps
`include "pkt_sched_macros.svh"

module pkt_sched_top (
  input  logic                     logic_clk,
  input  logic                     rst_n,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [`WB_ADR_W-1:0]     wb_adr,
  input  logic [`WB_DAT_W-1:0]     wb_dat_w,
  output logic [`WB_DAT_W-1:0]     wb_dat_r,
  output logic                     wb_ack,
  input  logic                     rx_pkt_valid,
  input  logic [`LEN_W-1:0]        rx_pkt_len,
  output logic                     rx_pkt_ready,
  output logic [`ADDR_W-1:0]       rx_desc_addr,
  output logic [`LEN_W-1:0]        rx_desc_len,
  output logic [`TAG_W-1:0]        rx_desc_tag,
  output logic                     rx_desc_valid,
  input  logic                     rx_desc_ready,
  output logic [`ADDR_W-1:0]       tx_desc_addr,
  output logic [`LEN_W-1:0]        tx_desc_len,
  output logic [`TAG_W-1:0]        tx_desc_tag,
  output logic                     tx_desc_valid,
  input  logic                     tx_desc_ready,
  input  pkt_sched_pkg::core_msg_u core_msg_data [`CORE_COUNT],
  input  logic [`CORE_COUNT-1:0]   core_msg_valid,
  output logic [`CORE_COUNT-1:0]   core_msg_ready
);
  import pkt_sched_pkg::*;

  // Arbiter to controller
  core_msg_u                              msg_data;
  core_idx_t                              msg_core;
  logic                                   msg_valid;
  logic                                   msg_ready;

  // Slot choice and slot state
  logic                                   sel_valid;
  core_idx_t                              sel_core;
  slot_idx_t                              sel_slot;
  logic                                   take;
  logic                                   set_busy;
  logic                                   clr_busy;
  core_idx_t                              set_core;
  core_idx_t                              clr_core;
  slot_idx_t                              set_slot;
  slot_idx_t                              clr_slot;
  core_idx_t                              rd_core;
  slot_idx_t                              rd_slot;
  logic [`SLOT_OFS_W-1:0]                 rd_ofs;
  logic [`CORE_COUNT-1:0][`SLOT_COUNT-1:0] slot_busy;
  logic [`CORE_COUNT-1:0]                 core_enable;

  sched_ctrl u_sched_ctrl (.*);

  slot_table u_slot_table (.*);

  core_select u_core_select (.*);

  core_msg_arbiter u_core_msg_arbiter (.*);

endmodule

// File: logic/sched_ctrl.sv
// Control FSM issuing receive and transmit descriptors
`timescale 1ns/1ps
`include "pkt_sched_macros.svh"

module sched_ctrl (
  input  logic                     logic_clk,
  input  logic                     rst_n,
  input  logic                     rx_pkt_valid,
  input  logic [`LEN_W-1:0]        rx_pkt_len,
  output logic                     rx_pkt_ready,
  output logic [`ADDR_W-1:0]       rx_desc_addr,
  output logic [`LEN_W-1:0]        rx_desc_len,
  output logic [`TAG_W-1:0]        rx_desc_tag,
  output logic                     rx_desc_valid,
  input  logic                     rx_desc_ready,
  output logic [`ADDR_W-1:0]       tx_desc_addr,
  output logic [`LEN_W-1:0]        tx_desc_len,
  output logic [`TAG_W-1:0]        tx_desc_tag,
  output logic                     tx_desc_valid,
  input  logic                     tx_desc_ready,
  input  pkt_sched_pkg::core_msg_u msg_data,
  input  pkt_sched_pkg::core_idx_t msg_core,
  input  logic                     msg_valid,
  output logic                     msg_ready,
  input  logic                     sel_valid,
  input  pkt_sched_pkg::core_idx_t sel_core,
  input  pkt_sched_pkg::slot_idx_t sel_slot,
  output logic                     take,
  output logic                     set_busy,
  output pkt_sched_pkg::core_idx_t set_core,
  output pkt_sched_pkg::slot_idx_t set_slot,
  output logic                     clr_busy,
  output pkt_sched_pkg::core_idx_t clr_core,
  output pkt_sched_pkg::slot_idx_t clr_slot,
  output pkt_sched_pkg::core_idx_t rd_core,
  output pkt_sched_pkg::slot_idx_t rd_slot,
  input  logic [`SLOT_OFS_W-1:0]   rd_ofs
);
  import pkt_sched_pkg::*;

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_RX   = 2'd1;
  localparam logic [1:0] ST_TX   = 2'd2;
  localparam int         TAG_PAD = `TAG_W - `CORE_W - `SLOT_W;

  logic [1:0]         state;
  logic               started;
  logic               idle;
  logic               in_tx;
  logic               msg_hs;
  logic               msg_drop;
  logic               rx_hs;
  logic [`ADDR_W-1:0] desc_addr;
  logic [`TAG_W-1:0]  desc_tag;

  assign idle      = (state == ST_IDLE);
  assign in_tx     = (state == ST_TX);
  assign msg_ready = idle;
  assign msg_hs    = msg_valid && msg_ready;
  assign msg_drop  = (msg_data.drop.kind == MSG_DROP);

  // Messages go ahead of frames
  assign rx_pkt_ready = idle && started && !msg_valid && sel_valid;
  assign rx_hs        = rx_pkt_valid && rx_pkt_ready;

  // Offset lookup follows the pending message, else the chosen slot
  assign rd_core   = msg_valid ? msg_core : sel_core;
  assign rd_slot   = msg_valid ? msg_data.send.slot : sel_slot;
  assign desc_addr = {rd_core, rd_ofs, {`SLOT_SHIFT{1'b0}}};
  assign desc_tag  = {{TAG_PAD{1'b0}}, rd_core, rd_slot};

  assign take     = rx_hs;
  assign set_busy = rx_hs;
  assign set_core = sel_core;
  assign set_slot = sel_slot;

  // Drop frees at once, send frees when the descriptor is taken
  assign clr_busy = (msg_hs && msg_drop) || (in_tx && tx_desc_ready);
  assign clr_core = in_tx ? tx_desc_tag[`CORE_W+`SLOT_W-1:`SLOT_W] : msg_core;
  assign clr_slot = in_tx ? tx_desc_tag[`SLOT_W-1:0] : msg_data.drop.slot;

  always_ff @(posedge logic_clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= ST_IDLE;
      started       <= 1'b0;
      rx_desc_valid <= 1'b0;
      tx_desc_valid <= 1'b0;
    end else begin
      started <= 1'b1;
      case (state)
        ST_IDLE: begin
          if (msg_hs && !msg_drop) begin
            tx_desc_valid <= 1'b1;
            state         <= ST_TX;
          end else if (rx_hs) begin
            rx_desc_valid <= 1'b1;
            state         <= ST_RX;
          end
        end
        ST_RX: begin
          if (rx_desc_ready) begin
            rx_desc_valid <= 1'b0;
            state         <= ST_IDLE;
          end
        end
        ST_TX: begin
          if (tx_desc_ready) begin
            tx_desc_valid <= 1'b0;
            state         <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge logic_clk) begin
    if (rx_hs) begin
      rx_desc_addr <= desc_addr;
      rx_desc_len  <= rx_pkt_len;
      rx_desc_tag  <= desc_tag;
    end
    if (msg_hs && !msg_drop) begin
      tx_desc_addr <= desc_addr;
      tx_desc_len  <= msg_data.send.len;
      tx_desc_tag  <= desc_tag;
    end
  end

endmodule

// File: logic/slot_table.sv
// Slot offsets, busy bits, core enable mask and the Wishbone host port
`timescale 1ns/1ps
`include "pkt_sched_macros.svh"

module slot_table (
  input  logic                                    logic_clk,
  input  logic                                    rst_n,
  input  logic                                    wb_cyc,
  input  logic                                    wb_stb,
  input  logic                                    wb_we,
  input  logic [`WB_ADR_W-1:0]                    wb_adr,
  input  logic [`WB_DAT_W-1:0]                    wb_dat_w,
  output logic [`WB_DAT_W-1:0]                    wb_dat_r,
  output logic                                    wb_ack,
  input  logic                                    set_busy,
  input  logic                                    clr_busy,
  input  pkt_sched_pkg::core_idx_t                set_core,
  input  pkt_sched_pkg::core_idx_t                clr_core,
  input  pkt_sched_pkg::slot_idx_t                set_slot,
  input  pkt_sched_pkg::slot_idx_t                clr_slot,
  input  pkt_sched_pkg::core_idx_t                rd_core,
  input  pkt_sched_pkg::slot_idx_t                rd_slot,
  output logic [`SLOT_OFS_W-1:0]                  rd_ofs,
  output logic [`CORE_COUNT-1:0][`SLOT_COUNT-1:0] slot_busy,
  output logic [`CORE_COUNT-1:0]                  core_enable
);

  localparam int ENTRIES = `CORE_COUNT * `SLOT_COUNT;
  localparam int IDX_W   = `CORE_W + `SLOT_W;

  logic [`SLOT_OFS_W-1:0] slot_ofs [ENTRIES];
  logic                   wb_req;
  logic                   ofs_sel;
  logic                   en_sel;
  logic [IDX_W-1:0]       wb_idx;

  // Held requests get one idle cycle after each ack
  assign wb_req  = wb_cyc && wb_stb && !wb_ack;
  assign ofs_sel = (wb_adr < `WB_ADR_W'(ENTRIES));
  assign en_sel  = (wb_adr == `WB_ADR_W'(`ENABLE_REG_ADR));
  assign wb_idx  = wb_adr[IDX_W-1:0];

  assign rd_ofs = slot_ofs[{rd_core, rd_slot}];

  always_ff @(posedge logic_clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= wb_req;
    end
  end

  always_ff @(posedge logic_clk) begin
    if (wb_req) begin
      if (ofs_sel) begin
        wb_dat_r <= `WB_DAT_W'(slot_ofs[wb_idx]);
      end else if (en_sel) begin
        wb_dat_r <= `WB_DAT_W'(core_enable);
      end else begin
        wb_dat_r <= '0;
      end
    end
  end

  // Default layout spaces slots 8 KiB apart inside each window
  always_ff @(posedge logic_clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < ENTRIES; i++) begin
        slot_ofs[i] <= `SLOT_OFS_W'((i % `SLOT_COUNT) * 16);
      end
      core_enable <= '1;
    end else if (wb_req && wb_we) begin
      if (ofs_sel) begin
        slot_ofs[wb_idx] <= wb_dat_w[`SLOT_OFS_W-1:0];
      end else if (en_sel) begin
        core_enable <= wb_dat_w[`CORE_COUNT-1:0];
      end
    end
  end

  always_ff @(posedge logic_clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_busy <= '0;
    end else begin
      if (set_busy) begin
        slot_busy[set_core][set_slot] <= 1'b1;
      end
      if (clr_busy) begin
        slot_busy[clr_core][clr_slot] <= 1'b0;
      end
    end
  end

  // Controller only hands out free slots
  assert property (@(posedge logic_clk) disable iff (!rst_n)
    set_busy |-> !slot_busy[set_core][set_slot]);

  // Cores only release slots they were given
  assert property (@(posedge logic_clk) disable iff (!rst_n)
    clr_busy |-> slot_busy[clr_core][clr_slot]);

endmodule

// File: sim/pkt_sched_checker.sv
// Reference model of the scheduler and comparison of its descriptors and host reads
`timescale 1ns/1ps
`include "pkt_sched_macros.svh"

module pkt_sched_checker (
  input logic                     logic_clk,
  input logic                     rst_n,
  input logic                     wb_cyc,
  input logic                     wb_stb,
  input logic                     wb_we,
  input logic [`WB_ADR_W-1:0]     wb_adr,
  input logic [`WB_DAT_W-1:0]     wb_dat_w,
  input logic [`WB_DAT_W-1:0]     wb_dat_r,
  input logic                     wb_ack,
  input logic                     rx_pkt_valid,
  input logic [`LEN_W-1:0]        rx_pkt_len,
  input logic                     rx_pkt_ready,
  input logic [`ADDR_W-1:0]       rx_desc_addr,
  input logic [`LEN_W-1:0]        rx_desc_len,
  input logic [`TAG_W-1:0]        rx_desc_tag,
  input logic                     rx_desc_valid,
  input logic                     rx_desc_ready,
  input logic [`ADDR_W-1:0]       tx_desc_addr,
  input logic [`LEN_W-1:0]        tx_desc_len,
  input logic [`TAG_W-1:0]        tx_desc_tag,
  input logic                     tx_desc_valid,
  input logic                     tx_desc_ready,
  input pkt_sched_pkg::core_msg_u core_msg_data [`CORE_COUNT],
  input logic [`CORE_COUNT-1:0]   core_msg_valid,
  input logic [`CORE_COUNT-1:0]   core_msg_ready
);
  import pkt_sched_pkg::*;

  localparam int DESC_W = `ADDR_W + `LEN_W + `TAG_W;

  int                     errors;
  logic [`SLOT_OFS_W-1:0] ofs_m [64];
  logic [63:0]            busy_m;
  logic [7:0]             en_m;
  int                     ptr_m;
  int                     msg_ptr_m;
  logic                   exp_ack;
  logic                   we_q;
  logic [`WB_DAT_W-1:0]   exp_rd;
  logic [DESC_W-1:0]      rx_q [$];
  logic [5:0]             tx_q [$];
  logic [`LEN_W-1:0]      send_len [64];
  logic                   rx_stall;
  logic                   tx_stall;
  logic [DESC_W-1:0]      rx_prev;
  logic [DESC_W-1:0]      tx_prev;

  task automatic cmp(input string name, input logic [31:0] exp, input logic [31:0] obs);
    if (exp !== obs) begin
      errors++;
      $display("[FAIL] %s expected %h observed %h", name, exp, obs);
    end
  endtask

  task automatic complain(input string what);
    errors++;
    $display("Error: %s", what);
  endtask

  // Next enabled core after the pointer that has a free slot, and its lowest free slot
  function automatic void pick(output logic ok, output int core, output int slot);
    int c;
    ok   = 1'b0;
    core = 0;
    slot = 0;
    for (int i = 1; i <= 8; i++) begin
      c = (ptr_m + i) % 8;
      if (!ok && en_m[c] && busy_m[c*8 +: 8] != 8'hff) begin
        ok   = 1'b1;
        core = c;
      end
    end
    for (int s = 7; s >= 0; s--) begin
      if (ok && !busy_m[core*8 + s]) slot = s;
    end
  endfunction

  function automatic logic [`ADDR_W-1:0] slot_addr(input int idx);
    return {3'(idx / 8), ofs_m[idx], 9'b0};
  endfunction

  always @(posedge logic_clk or negedge rst_n) begin
    logic ok;
    int   core;
    int   slot;
    int   idx;
    int   c;
    int   next_ptr;
    logic [DESC_W-1:0] d;
    if (!rst_n) begin
      for (int i = 0; i < 64; i++) begin
        ofs_m[i] = 7'((i % 8) * 16);
      end
      busy_m    = '0;
      en_m      = 8'hff;
      ptr_m     = 7;
      msg_ptr_m = 7;
      exp_ack   = 1'b0;
      rx_stall  = 1'b0;
      tx_stall  = 1'b0;
    end else begin
      // Host request seen now gets its ack after this edge
      if (wb_cyc && wb_stb && !exp_ack) begin
        we_q   = wb_we;
        exp_rd = wb_adr < 64 ? 8'(ofs_m[wb_adr]) : (wb_adr == 64 ? en_m : 8'h00);
        if (wb_we && wb_adr < 64) ofs_m[wb_adr] = wb_dat_w[6:0];
        if (wb_we && wb_adr == 64) en_m = wb_dat_w;
        exp_ack = 1'b1;
      end else begin
        exp_ack = 1'b0;
      end

      if (rx_stall && (!rx_desc_valid || {rx_desc_addr, rx_desc_len, rx_desc_tag} != rx_prev))
        complain("receive descriptor changed before its handshake");
      if (tx_stall && (!tx_desc_valid || {tx_desc_addr, tx_desc_len, tx_desc_tag} != tx_prev))
        complain("transmit descriptor changed before its handshake");
      rx_stall = rx_desc_valid && !rx_desc_ready;
      tx_stall = tx_desc_valid && !tx_desc_ready;
      rx_prev  = {rx_desc_addr, rx_desc_len, rx_desc_tag};
      tx_prev  = {tx_desc_addr, tx_desc_len, tx_desc_tag};

      if (rx_desc_valid && rx_desc_ready) begin
        if (rx_q.size() == 0) begin
          complain("receive descriptor issued without an accepted frame");
        end else begin
          d = rx_q.pop_front();
          cmp("rx_desc_addr", d[DESC_W-1 -: `ADDR_W], rx_desc_addr);
          cmp("rx_desc_len", d[`TAG_W +: `LEN_W], rx_desc_len);
          cmp("rx_desc_tag", d[`TAG_W-1:0], rx_desc_tag);
        end
      end

      if (tx_desc_valid && tx_desc_ready) begin
        if (tx_q.size() == 0) begin
          complain("transmit descriptor issued without a send message");
        end else begin
          idx = tx_q.pop_front();
          cmp("tx_desc_addr", slot_addr(idx), tx_desc_addr);
          cmp("tx_desc_len", send_len[idx], tx_desc_len);
          cmp("tx_desc_tag", 8'(idx), tx_desc_tag);
          busy_m[idx] = 1'b0;
        end
      end

      // Arbiter serves held messages round robin after the core served last
      next_ptr = msg_ptr_m;
      for (int i = 1; i <= 8; i++) begin
        c = (msg_ptr_m + i) % 8;
        if (core_msg_valid[c] && core_msg_ready[c]) begin
          idx = c * 8 + core_msg_data[c].send.slot;
          if (!busy_m[idx]) complain("message names a slot that is not in use");
          if (core_msg_data[c].drop.kind == MSG_DROP) begin
            busy_m[idx] = 1'b0;
          end else begin
            tx_q.push_back(6'(idx));
            send_len[idx] = core_msg_data[c].send.len;
          end
          next_ptr = c;
        end
      end
      msg_ptr_m = next_ptr;

      if (rx_pkt_valid && rx_pkt_ready) begin
        pick(ok, core, slot);
        if (!ok) begin
          complain("frame accepted with no free slot in an enabled core");
        end else begin
          idx = core * 8 + slot;
          rx_q.push_back({slot_addr(idx), rx_pkt_len, 8'(idx)});
          busy_m[idx] = 1'b1;
          ptr_m       = core;
        end
      end
    end
  end

  always @(negedge logic_clk) begin
    logic ok;
    int   core;
    int   slot;
    if (rst_n) begin
      cmp("wb_ack", exp_ack, wb_ack);
      if (wb_ack && exp_ack && !we_q) cmp("wb_dat_r", exp_rd, wb_dat_r);
      pick(ok, core, slot);
      if (rx_pkt_ready && !ok) complain("rx_pkt_ready high with every enabled slot busy");
    end
  end

  task automatic final_check();
    if (rx_q.size() != 0) complain("accepted frame never got its receive descriptor");
    if (tx_q.size() != 0) complain("send message never got its transmit descriptor");
  endtask

endmodule

// File: sim/tb_pkt_sched.sv
// Testbench for the packet scheduler with clock, reset, LFSR stimulus and timeout
`timescale 1ns/1ps
`include "pkt_sched_macros.svh"

module tb_pkt_sched;
  import pkt_sched_pkg::*;

  localparam int TXNS  = 260;
  localparam int LIMIT = 40 * TXNS + 200;

  logic                   logic_clk = 1'b0;
  logic                   rst_n;
  logic                   wb_cyc, wb_stb, wb_we, wb_ack;
  logic [`WB_ADR_W-1:0]   wb_adr;
  logic [`WB_DAT_W-1:0]   wb_dat_w, wb_dat_r;
  logic                   rx_pkt_valid, rx_pkt_ready;
  logic [`LEN_W-1:0]      rx_pkt_len;
  logic [`ADDR_W-1:0]     rx_desc_addr, tx_desc_addr;
  logic [`LEN_W-1:0]      rx_desc_len, tx_desc_len;
  logic [`TAG_W-1:0]      rx_desc_tag, tx_desc_tag;
  logic                   rx_desc_valid, rx_desc_ready, tx_desc_valid, tx_desc_ready;
  core_msg_u              core_msg_data [`CORE_COUNT];
  logic [`CORE_COUNT-1:0] core_msg_valid, core_msg_ready;

  logic [31:0] lfsr = 32'hcdd68460;
  int          cycles = 0;
  int          tb_errors = 0;
  int          last_errors = 0;
  int          tests_ok = 0;
  int          tests_bad = 0;
  int          rx_done = 0;
  int          tx_done = 0;
  int          rx_acc = 0;
  int          rx_want = 0;
  logic        rx_hs_q;
  logic [7:0]  core_hs_q;
  logic [5:0]  alloc [$];

  pkt_sched_top u_pkt_sched_top (.*);

  pkt_sched_checker u_checker (.*);

  always #50 logic_clk = ~logic_clk;

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  always @(posedge logic_clk) begin
    cycles++;
    if (cycles > LIMIT) begin
      $display("Run stopped after %0d cycles without finishing", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  always @(posedge logic_clk) begin
    rx_hs_q   <= rx_pkt_valid && rx_pkt_ready;
    core_hs_q <= core_msg_valid & core_msg_ready;
    if (rst_n && rx_pkt_valid && rx_pkt_ready) rx_acc++;
    if (rst_n && rx_desc_valid && rx_desc_ready) begin
      rx_done++;
      alloc.push_back(rx_desc_tag[5:0]);
    end
    if (rst_n && tx_desc_valid && tx_desc_ready) tx_done++;
  end

  // Descriptor consumers stall about one cycle in four
  always @(negedge logic_clk) begin
    if (rst_n) begin
      rx_desc_ready = rand_bits(2) != 0;
      tx_desc_ready = rand_bits(2) != 0;
    end
  end

  task automatic wb_access(input logic we, input int adr, input int dat);
    @(negedge logic_clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = 7'(adr);
    wb_dat_w = 8'(dat);
    do @(negedge logic_clk); while (!wb_ack);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  task automatic start_frame();
    @(negedge logic_clk);
    rx_pkt_valid = 1'b1;
    rx_pkt_len   = 16'(rand_bits(16));
    rx_want      = rx_acc + 1;
  endtask

  task automatic finish_frame();
    while (rx_acc < rx_want) @(negedge logic_clk);
    rx_pkt_valid = 1'b0;
    while (rx_done < rx_acc) @(negedge logic_clk);
  endtask

  task automatic frames(input int n);
    for (int i = 0; i < n; i++) begin
      start_frame();
      finish_frame();
    end
  endtask

  // Up to n messages at once from distinct cores, drops when drop_all is set
  task automatic messages(input int n, input logic drop_all);
    logic [5:0] keep [$];
    logic [7:0] used;
    int         sends;
    int         start;
    logic [5:0] t;
    used  = '0;
    sends = 0;
    start = alloc.size() > 0 ? rand_bits(6) % alloc.size() : 0;
    @(negedge logic_clk);
    for (int i = 0; i < alloc.size(); i++) begin
      t = alloc[(start + i) % alloc.size()];
      if ($countones(used) < n && !used[t[5:3]]) begin
        used[t[5:3]] = 1'b1;
        if (!drop_all && rand_bits(1)) begin
          core_msg_data[t[5:3]].send = {MSG_SEND, t[2:0], 12'(rand_bits(12)),
                                        16'(rand_bits(16)), rand_bits(32)};
          sends++;
        end else begin
          core_msg_data[t[5:3]].drop = {MSG_DROP, t[2:0], 28'(rand_bits(28)), rand_bits(32)};
        end
      end else begin
        keep.push_back(t);
      end
    end
    alloc          = keep;
    core_msg_valid = used;
    sends          = tx_done + sends;
    while (core_msg_valid != 0) begin
      @(negedge logic_clk);
      core_msg_valid = core_msg_valid & ~core_hs_q;
    end
    while (tx_done < sends) @(negedge logic_clk);
    // Drops free their slot a few cycles after the core hand-off
    repeat (4) @(negedge logic_clk);
  endtask

  task automatic finish_test(input string name);
    int now;
    now = u_checker.errors + tb_errors;
    if (now == last_errors) tests_ok++;
    else tests_bad++;
    $display("Test %-10s %s, %0d errors", name, now == last_errors ? "ok" : "bad",
             now - last_errors);
    last_errors = now;
  endtask

  initial begin
    rst_n = 1'b0;
    {wb_cyc, wb_stb, wb_we, wb_adr, wb_dat_w} = '0;
    {rx_pkt_valid, rx_pkt_len, rx_desc_ready, tx_desc_ready} = '0;
    core_msg_valid = '0;
    for (int c = 0; c < `CORE_COUNT; c++) core_msg_data[c] = '0;
    repeat (8) @(posedge logic_clk);
    @(negedge logic_clk);
    rst_n = 1'b1;

    for (int i = 0; i < 12; i++) begin
      int adr;
      adr = rand_bits(6);
      wb_access(1'b1, adr, rand_bits(7));
      wb_access(1'b0, adr, 0);
    end
    wb_access(1'b1, 100, 8'h5a);
    wb_access(1'b0, 100, 0);
    wb_access(1'b1, `ENABLE_REG_ADR, 8'hff);
    wb_access(1'b0, `ENABLE_REG_ADR, 0);
    finish_test("host");

    frames(24);
    finish_test("receive");

    for (int i = 0; i < 12; i++) messages(1, 1'b0);
    frames(6);
    finish_test("send");

    while (alloc.size() > 0) messages(1, 1'b1);
    wb_access(1'b1, `ENABLE_REG_ADR, 8'h03);
    frames(16);
    start_frame();
    repeat (20) begin
      @(negedge logic_clk);
      if (rx_hs_q) begin
        tb_errors++;
        $display("Error: frame accepted while every enabled slot was busy");
      end
    end
    messages(1, 1'b1);
    finish_frame();
    while (alloc.size() > 0) messages(4, 1'b1);
    finish_test("drop");

    wb_access(1'b1, `ENABLE_REG_ADR, 8'ha5);
    frames(20);
    while (alloc.size() > 0) messages(4, 1'b1);
    wb_access(1'b1, `ENABLE_REG_ADR, 8'hff);
    finish_test("enable");

    for (int i = 0; i < 30; i++) begin
      if (alloc.size() > 8 && rand_bits(1)) messages(4, 1'b0);
      else frames(2);
    end
    while (alloc.size() > 0) messages(4, 1'b0);
    repeat (4) @(negedge logic_clk);
    u_checker.final_check();
    finish_test("stress");

    $display("Tests: %0d ok, %0d bad, %0d errors", tests_ok, tests_bad,
             u_checker.errors + tb_errors);
    if (tests_bad == 0 && u_checker.errors + tb_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
